// ==== saturn_core.f ====
rtl/saturn_pkg.sv
rtl/saturn_alu_cmd_if.sv
rtl/saturn_reg_if.sv
rtl/saturn_decode.sv
rtl/saturn_execute.sv
rtl/saturn_result.sv
rtl/saturn_core.sv
test/tb_clock.sv
test/saturn_core_tb.sv

// ==== test/saturn_core_tb.sv ====
//************************************************************
// directed tests for the nibble-serial core
// register model, value checks and a watchdog
//************************************************************
module saturn_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import saturn_pkg::*;

    localparam int NUM_TESTS = 6;

    logic        clk;
    logic        por_reset;
    logic        soft_reset;
    logic        reset;
    logic        instr_valid;
    instr_type_t instr_type;
    alu_op_t     alu_opcode;
    reg_sel_t    reg_dest;
    reg_sel_t    reg_src_1;
    reg_sel_t    reg_src_2;
    logic [3:0]  ptr_begin;
    logic [3:0]  ptr_end;
    nibble_t     imm_value;
    reg_sel_t    dbg_register;
    logic [3:0]  dbg_reg_ptr;
    logic        busy;
    logic        error;
    nibble_t     reg_p;
    nibble_t     reg_hst;
    logic [15:0] reg_st;
    logic        reg_alu_mode;
    nibble_t     dbg_reg_nibble;

    // expected state
    nibble_t     m_reg [4][16];
    nibble_t     m_p;
    nibble_t     m_hst;
    logic [15:0] m_st;
    logic        m_mode;
    logic        m_error;

    int checks;
    int errors;

    assign reset = por_reset | soft_reset;

    tb_clock u_clock (
        .o_clk   (clk),
        .o_reset (por_reset)
    );

    saturn_core uut (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_instr_valid    (instr_valid),
        .i_instr_type     (instr_type),
        .i_alu_opcode     (alu_opcode),
        .i_reg_dest       (reg_dest),
        .i_reg_src_1      (reg_src_1),
        .i_reg_src_2      (reg_src_2),
        .i_ptr_begin      (ptr_begin),
        .i_ptr_end        (ptr_end),
        .i_imm_value      (imm_value),
        .o_busy           (busy),
        .o_error          (error),
        .o_reg_p          (reg_p),
        .o_reg_hst        (reg_hst),
        .o_reg_st         (reg_st),
        .o_reg_alu_mode   (reg_alu_mode),
        .i_dbg_register   (dbg_register),
        .i_dbg_reg_ptr    (dbg_reg_ptr),
        .o_dbg_reg_nibble (dbg_reg_nibble)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int r = 0; r < 4; r++) begin
            for (int n = 0; n < 16; n++) begin
                m_reg[r][n] = '0;
            end
        end
        m_p     = '0;
        m_hst   = '0;
        m_st    = '0;
        m_mode  = 1'b0;
        m_error = 1'b0;
    endtask

    // expected effect of one accepted instruction
    task automatic apply_model(input instr_type_t t, input alu_op_t op, input reg_sel_t d,
                               input reg_sel_t s1, input reg_sel_t s2,
                               input logic [3:0] b, input logic [3:0] e, input nibble_t imm);
        logic [3:0] pos;
        nibble_t    v1;
        nibble_t    v2;
        pos = b;
        if (t == INSTR_NOP) begin
            return;
        end else if (t == INSTR_SET_MODE) begin
            m_mode = imm[0];
        end else if (t == INSTR_LOAD) begin
            if (d == REG_C)
                m_reg[2][b] = imm;
            else
                m_error = 1'b1;
        end else if (t != INSTR_ALU) begin
            m_error = 1'b1;
        end else if (op == ALU_OP_CLR_MASK && d == REG_HST) begin
            m_hst = m_hst & ~imm;
        end else if (op == ALU_OP_COPY && d == REG_P && s1 == REG_IMM) begin
            m_p = imm;
        end else if (op == ALU_OP_COPY && d == REG_ST && s1 == REG_IMM) begin
            m_st[b] = imm[0];
        end else if (op == ALU_OP_COPY && d == REG_C && s1 == REG_P) begin
            m_reg[2][b] = m_p;
        end else if (d inside {REG_A, REG_B, REG_C, REG_D} &&
                     op inside {ALU_OP_ZERO, ALU_OP_COPY, ALU_OP_EXCH}) begin
            // begin to end inclusive, wrapping at 16
            for (int i = 0; i < 16; i++) begin
                v1 = (s1 == REG_IMM) ? imm : m_reg[s1[1:0]][pos];
                v2 = m_reg[s2[1:0]][pos];
                if (op == ALU_OP_ZERO) begin
                    m_reg[d[1:0]][pos] = '0;
                end else if (op == ALU_OP_COPY) begin
                    m_reg[d[1:0]][pos] = v1;
                end else begin
                    m_reg[d[1:0]][pos]  = v2;
                    m_reg[s2[1:0]][pos] = v1;
                end
                if (pos == e)
                    break;
                pos = pos + 1'b1;
            end
        end else begin
            m_error = 1'b1;
        end
    endtask

    task automatic drive_instr(input instr_type_t t, input alu_op_t op, input reg_sel_t d,
                               input reg_sel_t s1, input reg_sel_t s2,
                               input logic [3:0] b, input logic [3:0] e, input nibble_t imm);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr_type  <= t;
        alu_opcode  <= op;
        reg_dest    <= d;
        reg_src_1   <= s1;
        reg_src_2   <= s2;
        ptr_begin   <= b;
        ptr_end     <= e;
        imm_value   <= imm;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            errors++;
            $display("error at %0t ns: o_busy stayed high for 100 cycles", $time);
        end
    endtask

    // offer while idle, so it is taken on the next edge
    task automatic issue(input instr_type_t t, input alu_op_t op, input reg_sel_t d,
                         input reg_sel_t s1, input reg_sel_t s2,
                         input logic [3:0] b, input logic [3:0] e, input nibble_t imm);
        drive_instr(t, op, d, s1, s2, b, e, imm);
        @(posedge clk);
        instr_valid <= 1'b0;
        apply_model(t, op, d, s1, s2, b, e, imm);
        wait_idle();
    endtask

    task automatic check_reg(input reg_sel_t r);
        for (int n = 0; n < 16; n++) begin
            @(posedge clk);
            dbg_register <= r;
            dbg_reg_ptr  <= 4'(n);
            @(negedge clk);
            check($sformatf("%s[%0d]", r.name(), n), dbg_reg_nibble, m_reg[r[1:0]][n]);
        end
    endtask

    task automatic check_status();
        check("o_reg_p", reg_p, m_p);
        check("o_reg_hst", reg_hst, m_hst);
        check("o_reg_st", reg_st, m_st);
        check("o_reg_alu_mode", reg_alu_mode, m_mode);
        check("o_error", error, m_error);
    endtask

    task automatic test_reset();
        check_reg(REG_A);
        check_reg(REG_B);
        check_reg(REG_C);
        check_reg(REG_D);
        check_status();
        check("o_busy", busy, 1'b0);
    endtask

    task automatic test_load_and_p();
        logic [3:0] pos;
        nibble_t    n;
        repeat (4) begin
            pos = 4'($urandom);
            issue(INSTR_LOAD, ALU_OP_COPY, REG_C, REG_NONE, REG_NONE, pos, pos, 4'($urandom));
        end
        n = 4'($urandom);
        issue(INSTR_ALU, ALU_OP_COPY, REG_P, REG_IMM, REG_NONE, 4'h0, 4'h0, n);
        check_status();
        // C=P n puts P at nibble n
        issue(INSTR_ALU, ALU_OP_COPY, REG_C, REG_P, REG_NONE, n, n, 4'h0);
        issue(INSTR_SET_MODE, ALU_OP_ZERO, REG_NONE, REG_NONE, REG_NONE, 4'h0, 4'h0, 4'h1);
        check_status();
        issue(INSTR_SET_MODE, ALU_OP_ZERO, REG_NONE, REG_NONE, REG_NONE, 4'h0, 4'h0, 4'h6);
        check_status();
        check_reg(REG_C);
    endtask

    task automatic test_alu_ops();
        for (int i = 0; i < 16; i++) begin
            issue(INSTR_LOAD, ALU_OP_COPY, REG_C, REG_NONE, REG_NONE, 4'(i), 4'(i),
                  4'($urandom));
        end
        issue(INSTR_ALU, ALU_OP_COPY, REG_A, REG_C, REG_NONE, 4'h0, 4'hf, 4'h0);
        issue(INSTR_ALU, ALU_OP_COPY, REG_B, REG_IMM, REG_NONE, 4'($urandom), 4'($urandom),
              4'($urandom));
        // wraps past nibble 15
        issue(INSTR_ALU, ALU_OP_EXCH, REG_A, REG_A, REG_B, 4'hd, 4'h2, 4'h0);
        issue(INSTR_ALU, ALU_OP_COPY, REG_D, REG_B, REG_NONE, 4'($urandom), 4'($urandom),
              4'h0);
        issue(INSTR_ALU, ALU_OP_ZERO, REG_C, REG_NONE, REG_NONE, 4'($urandom), 4'($urandom),
              4'h0);
        check_reg(REG_A);
        check_reg(REG_B);
        check_reg(REG_C);
        check_reg(REG_D);
    endtask

    task automatic test_status();
        logic [3:0] b1;
        b1 = 4'($urandom);
        // status writes never raise busy, not even in the accepting cycle
        drive_instr(INSTR_ALU, ALU_OP_COPY, REG_ST, REG_IMM, REG_NONE, b1, b1, 4'h1);
        @(negedge clk);
        check("o_busy", busy, 1'b0);
        @(posedge clk);
        instr_valid <= 1'b0;
        apply_model(INSTR_ALU, ALU_OP_COPY, REG_ST, REG_IMM, REG_NONE, b1, b1, 4'h1);
        @(negedge clk);
        check("o_busy", busy, 1'b0);
        check_status();
        issue(INSTR_ALU, ALU_OP_COPY, REG_ST, REG_IMM, REG_NONE, b1 + 4'h5, b1, 4'h3);
        check_status();
        issue(INSTR_ALU, ALU_OP_COPY, REG_ST, REG_IMM, REG_NONE, b1, b1, 4'he);
        check_status();
        issue(INSTR_ALU, ALU_OP_CLR_MASK, REG_HST, REG_IMM, REG_NONE, 4'h0, 4'h0,
              4'($urandom));
        check_status();
    endtask

    task automatic test_busy_ignore();
        nibble_t n;
        // a P value that differs from the current one
        n = m_p ^ 4'($urandom_range(15, 1));
        drive_instr(INSTR_ALU, ALU_OP_COPY, REG_D, REG_IMM, REG_NONE, 4'h0, 4'hf, 4'($urandom));
        @(posedge clk);
        instr_valid <= 1'b0;
        apply_model(instr_type, alu_opcode, reg_dest, reg_src_1, reg_src_2,
                    ptr_begin, ptr_end, imm_value);
        // P=n held while the copy runs
        drive_instr(INSTR_ALU, ALU_OP_COPY, REG_P, REG_IMM, REG_NONE, 4'h0, 4'h0, n);
        repeat (4) @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check("o_busy", busy, 1'b1);
        check_status();
        wait_idle();
        check_status();
        issue(INSTR_ALU, ALU_OP_COPY, REG_P, REG_IMM, REG_NONE, 4'h0, 4'h0, n);
        check_status();
        check_reg(REG_D);
    endtask

    task automatic test_errors();
        issue(instr_type_t'(4'h9), ALU_OP_COPY, REG_A, REG_IMM, REG_NONE, 4'h0, 4'h0, 4'h5);
        check_status();
        // error stays set across later good instructions
        issue(INSTR_ALU, ALU_OP_COPY, REG_P, REG_IMM, REG_NONE, 4'h0, 4'h0, 4'h2);
        check_status();
        @(posedge clk);
        soft_reset <= 1'b1;
        repeat (2) @(posedge clk);
        soft_reset <= 1'b0;
        reset_model();
        @(negedge clk);
        check_status();
        check("o_busy", busy, 1'b0);
        check_reg(REG_A);
        // load into D is rejected and leaves D alone
        issue(INSTR_LOAD, ALU_OP_COPY, REG_D, REG_NONE, REG_NONE, 4'h3, 4'h3, 4'ha);
        check_status();
        check_reg(REG_D);
    endtask

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        soft_reset   = 1'b0;
        instr_valid  = 1'b0;
        instr_type   = INSTR_NOP;
        alu_opcode   = ALU_OP_ZERO;
        reg_dest     = REG_NONE;
        reg_src_1    = REG_NONE;
        reg_src_2    = REG_NONE;
        ptr_begin    = '0;
        ptr_end      = '0;
        imm_value    = '0;
        dbg_register = REG_A;
        dbg_reg_ptr  = '0;
        checks       = 0;
        errors       = 0;
        void'($urandom(32'hfa8d));
        reset_model();
        wait (por_reset == 1'b0);
        test_reset();
        test_load_and_p();
        test_alu_ops();
        test_status();
        test_busy_ignore();
        test_errors();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
//************************************************************
// testbench clock, 4 ns period, and power-on reset
//************************************************************
module tb_clock (
    output logic o_clk,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // reset held for two rising edges
    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

// ==== rtl/saturn_core.sv ====
//************************************************************
// instruction-execution core of the calculator control unit
//************************************************************
module saturn_core #(
    parameter int REG_NIBBLES = 16
) (
    input  logic                                          i_clk,
    input  logic                                          i_reset,
    input  logic                                          i_instr_valid,
    input  saturn_pkg::instr_type_t                       i_instr_type,
    input  saturn_pkg::alu_op_t                           i_alu_opcode,
    input  saturn_pkg::reg_sel_t                          i_reg_dest,
    input  saturn_pkg::reg_sel_t                          i_reg_src_1,
    input  saturn_pkg::reg_sel_t                          i_reg_src_2,
    input  logic [$clog2(saturn_pkg::REG_NIBBLES_MAX)-1:0] i_ptr_begin,
    input  logic [$clog2(saturn_pkg::REG_NIBBLES_MAX)-1:0] i_ptr_end,
    input  saturn_pkg::nibble_t                           i_imm_value,
    output logic                                          o_busy,
    output logic                                          o_error,
    output saturn_pkg::nibble_t                           o_reg_p,
    output saturn_pkg::nibble_t                           o_reg_hst,
    output logic [saturn_pkg::REG_NIBBLES_MAX-1:0]        o_reg_st,
    output logic                                          o_reg_alu_mode,
    input  saturn_pkg::reg_sel_t                          i_dbg_register,
    input  logic [$clog2(saturn_pkg::REG_NIBBLES_MAX)-1:0] i_dbg_reg_ptr,
    output saturn_pkg::nibble_t                           o_dbg_reg_nibble
);

    saturn_alu_cmd_if alu_cmd ();
    saturn_reg_if     reg_bus ();

    saturn_decode u_decode (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr_valid  (i_instr_valid),
        .i_instr_type   (i_instr_type),
        .i_alu_opcode   (i_alu_opcode),
        .i_reg_dest     (i_reg_dest),
        .i_reg_src_1    (i_reg_src_1),
        .i_reg_src_2    (i_reg_src_2),
        .i_ptr_begin    (i_ptr_begin),
        .i_ptr_end      (i_ptr_end),
        .i_imm_value    (i_imm_value),
        .o_busy         (o_busy),
        .o_error        (o_error),
        .o_reg_p        (o_reg_p),
        .o_reg_hst      (o_reg_hst),
        .o_reg_st       (o_reg_st),
        .o_reg_alu_mode (o_reg_alu_mode),
        .alu            (alu_cmd)
    );

    saturn_execute #(
        .REG_NIBBLES (REG_NIBBLES)
    ) u_execute (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .alu     (alu_cmd),
        .regs    (reg_bus)
    );

    saturn_result #(
        .REG_NIBBLES (REG_NIBBLES)
    ) u_result (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .regs             (reg_bus),
        .i_dbg_register   (i_dbg_register),
        .i_dbg_reg_ptr    (i_dbg_reg_ptr),
        .o_dbg_reg_nibble (o_dbg_reg_nibble)
    );

endmodule

// ==== rtl/saturn_result.sv ====
//************************************************************
// working registers A..D with two write ports and debug read
//************************************************************
module saturn_result #(
    parameter int REG_NIBBLES = 16
) (
    input  logic                                          i_clk,
    input  logic                                          i_reset,
    saturn_reg_if.result                                  regs,
    input  saturn_pkg::reg_sel_t                          i_dbg_register,
    input  logic [$clog2(saturn_pkg::REG_NIBBLES_MAX)-1:0] i_dbg_reg_ptr,
    output saturn_pkg::nibble_t                           o_dbg_reg_nibble
);
    import saturn_pkg::*;

    localparam int PTR_W = $clog2(REG_NIBBLES_MAX);

    // indexed by the low two bits of the selector
    nibble_t file_q [4][REG_NIBBLES];

    function automatic logic is_work(input reg_sel_t sel);
        return sel inside {REG_A, REG_B, REG_C, REG_D};
    endfunction

    // anything outside A..D or past the register length reads zero
    function automatic nibble_t read_nibble(input reg_sel_t sel, input logic [PTR_W-1:0] pos);
        if (is_work(sel) && pos < REG_NIBBLES)
            return file_q[sel[1:0]][pos];
        return '0;
    endfunction

    always_comb begin
        regs.rd_val_1    = read_nibble(regs.rd_sel_1, regs.rd_pos);
        regs.rd_val_2    = read_nibble(regs.rd_sel_2, regs.rd_pos);
        o_dbg_reg_nibble = read_nibble(i_dbg_register, i_dbg_reg_ptr);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int r = 0; r < 4; r++) begin
                for (int n = 0; n < REG_NIBBLES; n++) begin
                    file_q[r][n] <= '0;
                end
            end
        end else begin
            if (regs.we_1 && is_work(regs.wr_sel_1))
                file_q[regs.wr_sel_1[1:0]][regs.wr_pos] <= regs.wr_val_1;
            // second port only for exch
            if (regs.we_2 && is_work(regs.wr_sel_2))
                file_q[regs.wr_sel_2[1:0]][regs.wr_pos] <= regs.wr_val_2;
        end
    end

    a_no_write_clash : assert property (@(posedge i_clk) disable iff (i_reset)
        !(regs.we_1 && regs.we_2 && regs.wr_sel_1 == regs.wr_sel_2));

endmodule

// ==== rtl/saturn_execute.sv ====
//************************************************************
// three-stage nibble-serial ALU pipeline
// prepare, calculate and save, one nibble per cycle
//************************************************************
module saturn_execute #(
    parameter int REG_NIBBLES = 16
) (
    input  logic              i_clk,
    input  logic              i_reset,
    saturn_alu_cmd_if.execute alu,
    saturn_reg_if.execute     regs
);
    import saturn_pkg::*;

    localparam int PTR_W = $clog2(REG_NIBBLES_MAX);

    // latched command
    alu_op_t    op_q;
    reg_sel_t   dest_q;
    reg_sel_t   src_1_q;
    reg_sel_t   src_2_q;
    logic [PTR_W-1:0] end_q;
    nibble_t    imm_q;

    logic             prep_run;
    logic [PTR_W-1:0] prep_pos;
    logic             calc_run;
    logic [PTR_W-1:0] calc_pos;
    logic             save_run;
    logic [PTR_W-1:0] save_pos;

    nibble_t src_1_val;
    nibble_t src_2_val;
    nibble_t res_1;
    nibble_t res_2;

    function automatic logic [PTR_W-1:0] step(input logic [PTR_W-1:0] pos);
        return (pos == PTR_W'(REG_NIBBLES - 1)) ? '0 : pos + 1'b1;
    endfunction

    assign alu.busy = prep_run || calc_run || save_run;

    assign regs.rd_sel_1 = src_1_q;
    assign regs.rd_sel_2 = src_2_q;
    assign regs.rd_pos   = prep_pos;

    assign regs.we_1     = save_run;
    assign regs.wr_sel_1 = dest_q;
    assign regs.wr_val_1 = res_1;
    assign regs.we_2     = save_run && op_q == ALU_OP_EXCH;
    assign regs.wr_sel_2 = src_2_q;
    assign regs.wr_val_2 = res_2;
    assign regs.wr_pos   = save_pos;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            op_q     <= ALU_OP_ZERO;
            end_q    <= '0;
            prep_run <= 1'b0;
            calc_run <= 1'b0;
            save_run <= 1'b0;
        end else if (alu.start) begin
            op_q     <= alu.op;
            end_q    <= alu.ptr_end;
            // zero has nothing to read, go straight to save
            prep_run <= alu.op != ALU_OP_ZERO;
            save_run <= alu.op == ALU_OP_ZERO;
            prep_pos <= alu.ptr_begin;
            save_pos <= alu.ptr_begin;
        end else begin
            if (prep_run) begin
                prep_pos <= step(prep_pos);
                if (prep_pos == end_q)
                    prep_run <= 1'b0;
            end
            calc_run <= prep_run;
            calc_pos <= prep_pos;
            if (op_q == ALU_OP_ZERO) begin
                save_pos <= step(save_pos);
                if (save_pos == end_q)
                    save_run <= 1'b0;
            end else begin
                save_run <= calc_run;
                save_pos <= calc_pos;
            end
        end
    end

    // payload path
    always_ff @(posedge i_clk) begin
        if (alu.start) begin
            dest_q  <= alu.dest;
            src_1_q <= alu.src_1;
            src_2_q <= alu.src_2;
            imm_q   <= alu.imm;
            res_1   <= '0;
        end
        if (prep_run) begin
            src_1_val <= (src_1_q == REG_IMM) ? imm_q : regs.rd_val_1;
            src_2_val <= (src_2_q == REG_IMM) ? imm_q : regs.rd_val_2;
        end
        if (calc_run) begin
            res_1 <= (op_q == ALU_OP_EXCH) ? src_2_val : src_1_val;
            res_2 <= src_1_val;
        end
    end

    // busy ends right after the save of the last position
    a_last_save : assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(alu.busy) |-> $past(regs.we_1 && regs.wr_pos == end_q));

    a_dest_work : assert property (@(posedge i_clk) disable iff (i_reset)
        alu.start |-> alu.dest inside {REG_A, REG_B, REG_C, REG_D});

endmodule

// ==== rtl/saturn_decode.sv ====
//************************************************************
// instruction classifier, status registers and ALU dispatch
//************************************************************
module saturn_decode (
    input  logic                                          i_clk,
    input  logic                                          i_reset,
    input  logic                                          i_instr_valid,
    input  saturn_pkg::instr_type_t                       i_instr_type,
    input  saturn_pkg::alu_op_t                           i_alu_opcode,
    input  saturn_pkg::reg_sel_t                          i_reg_dest,
    input  saturn_pkg::reg_sel_t                          i_reg_src_1,
    input  saturn_pkg::reg_sel_t                          i_reg_src_2,
    input  logic [$clog2(saturn_pkg::REG_NIBBLES_MAX)-1:0] i_ptr_begin,
    input  logic [$clog2(saturn_pkg::REG_NIBBLES_MAX)-1:0] i_ptr_end,
    input  saturn_pkg::nibble_t                           i_imm_value,
    output logic                                          o_busy,
    output logic                                          o_error,
    output saturn_pkg::nibble_t                           o_reg_p,
    output saturn_pkg::nibble_t                           o_reg_hst,
    output logic [saturn_pkg::REG_NIBBLES_MAX-1:0]        o_reg_st,
    output logic                                          o_reg_alu_mode,
    saturn_alu_cmd_if.decode                              alu
);
    import saturn_pkg::*;

    logic accept;
    logic is_alu;
    logic dest_work;
    logic is_p_eq_n;
    logic is_clr_hst;
    logic is_st_eq;
    logic is_c_eq_p;
    logic is_load_c;
    logic is_generic;
    logic routed;
    logic supported;

    // busy is registered in execute, so no loop through start
    assign accept    = i_instr_valid && !alu.busy;
    assign is_alu    = (i_instr_type == INSTR_ALU);
    assign dest_work = i_reg_dest inside {REG_A, REG_B, REG_C, REG_D};

    assign is_p_eq_n  = is_alu && i_alu_opcode == ALU_OP_COPY &&
                        i_reg_dest == REG_P && i_reg_src_1 == REG_IMM;
    assign is_clr_hst = is_alu && i_alu_opcode == ALU_OP_CLR_MASK && i_reg_dest == REG_HST;
    assign is_st_eq   = is_alu && i_alu_opcode == ALU_OP_COPY &&
                        i_reg_dest == REG_ST && i_reg_src_1 == REG_IMM;
    assign is_c_eq_p  = is_alu && i_alu_opcode == ALU_OP_COPY &&
                        i_reg_dest == REG_C && i_reg_src_1 == REG_P;
    assign is_load_c  = (i_instr_type == INSTR_LOAD) && i_reg_dest == REG_C;

    // generic ops over A..D, exch also writes back into src_2
    assign is_generic = is_alu && dest_work && (
        i_alu_opcode == ALU_OP_ZERO ||
        (i_alu_opcode == ALU_OP_COPY &&
         i_reg_src_1 inside {REG_A, REG_B, REG_C, REG_D, REG_IMM}) ||
        (i_alu_opcode == ALU_OP_EXCH &&
         i_reg_src_1 inside {REG_A, REG_B, REG_C, REG_D} &&
         i_reg_src_2 inside {REG_A, REG_B, REG_C, REG_D}));

    assign routed    = is_c_eq_p || is_load_c || is_generic;
    assign supported = routed || is_p_eq_n || is_clr_hst || is_st_eq ||
                       i_instr_type == INSTR_NOP || i_instr_type == INSTR_SET_MODE;

    assign alu.start = accept && routed;
    assign o_busy    = alu.busy || alu.start;

    always_comb begin
        alu.op        = i_alu_opcode;
        alu.dest      = i_reg_dest;
        alu.src_1     = i_reg_src_1;
        alu.src_2     = i_reg_src_2;
        alu.ptr_begin = i_ptr_begin;
        alu.ptr_end   = i_ptr_end;
        alu.imm       = i_imm_value;
        // C=P n and LOAD C become one-nibble copies of an immediate
        if (is_c_eq_p || is_load_c) begin
            alu.op      = ALU_OP_COPY;
            alu.src_1   = REG_IMM;
            alu.src_2   = REG_NONE;
            alu.ptr_end = i_ptr_begin;
            alu.imm     = is_c_eq_p ? o_reg_p : i_imm_value;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_p        <= '0;
            o_reg_hst      <= '0;
            o_reg_st       <= '0;
            o_reg_alu_mode <= 1'b0;
            o_error        <= 1'b0;
        end else if (accept) begin
            if (is_p_eq_n)
                o_reg_p <= i_imm_value;
            if (is_clr_hst)
                o_reg_hst <= o_reg_hst & ~i_imm_value;
            if (is_st_eq)
                o_reg_st[i_ptr_begin] <= i_imm_value[0];
            // 0 is hex, 1 is decimal
            if (i_instr_type == INSTR_SET_MODE)
                o_reg_alu_mode <= i_imm_value[0];
            if (!supported)
                o_error <= 1'b1;
        end
    end

    // execute picks up every command on the edge that starts it
    a_start_taken : assert property (@(posedge i_clk) disable iff (i_reset)
        alu.start |=> alu.busy);

endmodule

// ==== rtl/saturn_reg_if.sv ====
//************************************************************
// nibble read and write ports into the register file
//************************************************************
interface saturn_reg_if;
    import saturn_pkg::*;

    // read side, values come back in the same cycle
    reg_sel_t                           rd_sel_1;
    reg_sel_t                           rd_sel_2;
    logic [$clog2(REG_NIBBLES_MAX)-1:0] rd_pos;
    nibble_t                            rd_val_1;
    nibble_t                            rd_val_2;

    // write side, both ports share one position
    logic                               we_1;
    reg_sel_t                           wr_sel_1;
    nibble_t                            wr_val_1;
    logic                               we_2;
    reg_sel_t                           wr_sel_2;
    nibble_t                            wr_val_2;
    logic [$clog2(REG_NIBBLES_MAX)-1:0] wr_pos;

    modport execute (
        output rd_sel_1, rd_sel_2, rd_pos,
        input  rd_val_1, rd_val_2,
        output we_1, wr_sel_1, wr_val_1, we_2, wr_sel_2, wr_val_2, wr_pos
    );

    modport result (
        input  rd_sel_1, rd_sel_2, rd_pos,
        output rd_val_1, rd_val_2,
        input  we_1, wr_sel_1, wr_val_1, we_2, wr_sel_2, wr_val_2, wr_pos
    );

endinterface

// ==== rtl/saturn_alu_cmd_if.sv ====
//************************************************************
// one ALU command from decode to the execute pipeline
//************************************************************
interface saturn_alu_cmd_if;
    import saturn_pkg::*;

    logic                               start;
    alu_op_t                            op;
    reg_sel_t                           dest;
    reg_sel_t                           src_1;
    reg_sel_t                           src_2;
    logic [$clog2(REG_NIBBLES_MAX)-1:0] ptr_begin;
    logic [$clog2(REG_NIBBLES_MAX)-1:0] ptr_end;
    nibble_t                            imm;
    logic                               busy;

    modport decode (
        output start, op, dest, src_1, src_2, ptr_begin, ptr_end, imm,
        input  busy
    );

    modport execute (
        input  start, op, dest, src_1, src_2, ptr_begin, ptr_end, imm,
        output busy
    );

endinterface

// ==== rtl/saturn_pkg.sv ====
//************************************************************
// shared codes and types for the nibble-serial core
//************************************************************
package saturn_pkg;

    // largest register length in nibbles, pointers are sized from it
    localparam int REG_NIBBLES_MAX = 16;

    typedef logic [3:0] nibble_t;

    // working registers A..D must stay at codes 0..3
    typedef enum logic [3:0] {
        REG_A    = 4'h0,
        REG_B    = 4'h1,
        REG_C    = 4'h2,
        REG_D    = 4'h3,
        REG_P    = 4'h4,
        REG_HST  = 4'h5,
        REG_ST   = 4'h6,
        REG_IMM  = 4'h7,
        REG_NONE = 4'hf
    } reg_sel_t;

    typedef enum logic [3:0] {
        ALU_OP_ZERO     = 4'h0,
        ALU_OP_COPY     = 4'h1,
        ALU_OP_EXCH     = 4'h2,
        ALU_OP_CLR_MASK = 4'h3
    } alu_op_t;

    typedef enum logic [3:0] {
        INSTR_NOP      = 4'h0,
        INSTR_ALU      = 4'h1,
        INSTR_SET_MODE = 4'h2,
        INSTR_LOAD     = 4'h3
    } instr_type_t;

endpackage
